// File: Bender.yml
package:
  name: neuralLayer

sources:
  - include_dirs:
      - source
    files:
      - source/neuralLayerPkg.sv
      - source/weightStore.sv
      - source/reluNeuron.sv
      - source/resultQueue.sv
      - source/neuralLayer.sv

  - target: test
    include_dirs:
      - source
    files:
      - verification/neuralLayerTb.sv

// File: neuralLayer.f
+incdir+source
source/neuralLayerPkg.sv
source/weightStore.sv
source/reluNeuron.sv
source/resultQueue.sv
source/neuralLayer.sv
verification/neuralLayerTb.sv

// File: source/neuralLayer.sv
`default_nettype none

`include "neuralLayer_settings.svh"

module neuralLayer
(
	input wire logic clk,
	input wire logic reset,

	// Weight and bias loading, one register per cycle
	input wire logic weightValid,
	input wire neuralLayerPkg::weightWrite_t weightData,

	// Feature vectors from upstream
	input wire logic inValid,
	input wire neuralLayerPkg::featureVector_t inData,
	output logic inCredit,

	// Results to downstream
	input wire logic outCredit,
	output logic outValid,
	output neuralLayerPkg::layerResult_t outData
);

	import neuralLayerPkg::*;

	neuronWeights_t [`LAYER_NEURONS-1:0] neuronWeights;
	layerResult_t layerResult;
	logic layerValid;

	weightStore store
	(
		.clk(clk),
		.reset(reset),
		.weightValid(weightValid),
		.weightData(weightData),
		.neuronWeights(neuronWeights)
	);

	// All neurons share one pipeline so neuron 0 carries the valid
	for (genvar g = 0; g < `LAYER_NEURONS; g++)
	begin : gNeuron
		if (g == 0)
		begin : gLead
			reluNeuron neuron
			(
				.clk(clk),
				.reset(reset),
				.inValid(inValid),
				.inData(inData),
				.weights(neuronWeights[g]),
				.outValid(layerValid),
				.activation(layerResult.activation[g])
			);
		end
		else
		begin : gFollow
			reluNeuron neuron
			(
				.clk(clk),
				.reset(reset),
				.inValid(inValid),
				.inData(inData),
				.weights(neuronWeights[g]),
				.outValid(),
				.activation(layerResult.activation[g])
			);
		end
	end

	// Output side of the credit loop
	resultQueue queue
	(
		.clk(clk),
		.reset(reset),
		.writeValid(layerValid),
		.writeData(layerResult),
		.outCredit(outCredit),
		.outValid(outValid),
		.outData(outData),
		.inCredit(inCredit)
	);

endmodule

`default_nettype wire

// File: source/neuralLayerPkg.sv
`default_nettype none

`include "neuralLayer_settings.svh"

package neuralLayerPkg;

	// Target of a weight write
	typedef enum logic
	{
		opWeight,
		opBias
	} weightOp_t;

	// Named signed word so elements of packed arrays stay signed
	typedef logic signed [`DATA_WIDTH-1:0] dataWord_t;

	typedef struct packed
	{
		dataWord_t [`LAYER_INPUTS-1:0] data;
	} featureVector_t;

	typedef struct packed
	{
		weightOp_t op;
		logic [$clog2(`LAYER_NEURONS)-1:0] neuronIndex;
		// Don't care for bias writes
		logic [$clog2(`LAYER_INPUTS)-1:0] inputIndex;
		dataWord_t value;
	} weightWrite_t;

	typedef struct packed
	{
		dataWord_t [`LAYER_INPUTS-1:0] weight;
		dataWord_t bias;
	} neuronWeights_t;

	// Post-ReLU outputs are never negative
	typedef struct packed
	{
		logic [`LAYER_NEURONS-1:0][`DATA_WIDTH-1:0] activation;
	} layerResult_t;

endpackage

`default_nettype wire

// File: source/neuralLayer_settings.svh
`ifndef NEURAL_LAYER_SETTINGS_SVH
`define NEURAL_LAYER_SETTINGS_SVH

// Features per input vector
`define LAYER_INPUTS 15

// Neurons in the layer, all fed the same vector
`define LAYER_NEURONS 4

// Width of features, weights, biases and activations
`define DATA_WIDTH 8

// Result queue entries
// Also the number of credits the upstream holds after reset
`define QUEUE_DEPTH 4

// Wide enough to count up to QUEUE_DEPTH
`define CREDIT_WIDTH 3

`endif

// File: source/reluNeuron.sv
`default_nettype none

`include "neuralLayer_settings.svh"

module reluNeuron
(
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire neuralLayerPkg::featureVector_t inData,
	input wire neuralLayerPkg::neuronWeights_t weights,
	output logic outValid,
	output logic [7:0] activation
);

	import neuralLayerPkg::*;

	featureVector_t featureReg;
	logic featureValid;
	logic signed [2*`DATA_WIDTH-1:0] product [`LAYER_INPUTS];
	logic [`DATA_WIDTH-1:0] sumNext;
	logic [`DATA_WIDTH-1:0] sumReg;
	logic sumValid;

	// Valid bit follows the three data stages
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featureValid <= 1'b0;
			sumValid <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			featureValid <= inValid;
			sumValid <= featureValid;
			outValid <= sumValid;
		end
	end

	// Stage 1 captures the features
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			featureReg <= inData;
		end
	end

	// Full products, of which only the low byte is summed
	always_comb
	begin
		for (int i = 0; i < `LAYER_INPUTS; i++)
		begin
			product[i] = featureReg.data[i] * weights.weight[i];
		end
	end

	// Wraps modulo 256, no saturation
	always_comb
	begin
		sumNext = weights.bias;
		for (int i = 0; i < `LAYER_INPUTS; i++)
		begin
			sumNext = sumNext + product[i][`DATA_WIDTH-1:0];
		end
	end

	// Stage 2 holds the sum, stage 3 the ReLU output
	always_ff @(posedge clk)
	begin
		sumReg <= sumNext;
		if (sumReg[`DATA_WIDTH-1])
		begin
			activation <= '0;
		end
		else
		begin
			activation <= sumReg;
		end
	end

endmodule

`default_nettype wire

// File: source/resultQueue.sv
`default_nettype none

`include "neuralLayer_settings.svh"

module resultQueue
(
	input wire logic clk,
	input wire logic reset,
	input wire logic writeValid,
	input wire neuralLayerPkg::layerResult_t writeData,
	input wire logic outCredit,
	output logic outValid,
	output neuralLayerPkg::layerResult_t outData,
	output logic inCredit
);

	import neuralLayerPkg::*;

	localparam int PTR_WIDTH = $clog2(`QUEUE_DEPTH);
	localparam int LAST_ENTRY = `QUEUE_DEPTH - 1;

	layerResult_t entries [`QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0] writePtr;
	logic [PTR_WIDTH-1:0] readPtr;
	logic [`CREDIT_WIDTH-1:0] count;
	logic [`CREDIT_WIDTH-1:0] credits;
	logic notEmpty;
	logic haveCredit;
	logic pop;

	function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(LAST_ENTRY))
		begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign notEmpty = count != '0;
	assign haveCredit = credits != '0;

	// One entry leaves per cycle while both hold
	assign pop = notEmpty && haveCredit;

	// Every pop hands one credit back upstream
	assign outValid = pop;
	assign inCredit = pop;
	assign outData = entries[readPtr];

	// Upstream credits keep writes off a full queue
	always_ff @(posedge clk)
	begin
		if (writeValid)
		begin
			entries[writePtr] <= writeData;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			writePtr <= '0;
			readPtr <= '0;
		end
		else
		begin
			if (writeValid)
			begin
				writePtr <= nextPtr(writePtr);
			end
			if (pop)
			begin
				readPtr <= nextPtr(readPtr);
			end
		end
	end

	// Occupancy, write and pop may coincide
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
		end
		else
		begin
			case ({writeValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Downstream credits, grant and spend in one cycle cancel
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credits <= '0;
		end
		else
		begin
			case ({outCredit, pop})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/weightStore.sv
`default_nettype none

`include "neuralLayer_settings.svh"

module weightStore
(
	input wire logic clk,
	input wire logic reset,
	input wire logic weightValid,
	input wire neuralLayerPkg::weightWrite_t weightData,
	output neuralLayerPkg::neuronWeights_t [`LAYER_NEURONS-1:0] neuronWeights
);

	import neuralLayerPkg::*;

	logic [`LAYER_NEURONS-1:0] neuronSelect;
	logic [`LAYER_INPUTS-1:0] inputSelect;
	logic biasWrite;
	logic weightWrite;

	// One-hot neuron select from the write index
	always_comb
	begin
		neuronSelect = '0;
		if (weightValid)
		begin
			neuronSelect[weightData.neuronIndex] = 1'b1;
		end
	end

	// Index 15 selects nothing
	always_comb
	begin
		inputSelect = '0;
		for (int i = 0; i < `LAYER_INPUTS; i++)
		begin
			if (weightData.inputIndex == i)
			begin
				inputSelect[i] = 1'b1;
			end
		end
	end

	assign biasWrite = weightData.op == opBias;
	assign weightWrite = weightData.op == opWeight;

	// At most one register changes per cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			neuronWeights <= '0;
		end
		else
		begin
			for (int n = 0; n < `LAYER_NEURONS; n++)
			begin
				if (neuronSelect[n] && biasWrite)
				begin
					neuronWeights[n].bias <= weightData.value;
				end
				for (int i = 0; i < `LAYER_INPUTS; i++)
				begin
					if (neuronSelect[n] && weightWrite && inputSelect[i])
					begin
						neuronWeights[n].weight[i] <= weightData.value;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/neuralLayerTb.sv
`default_nettype none

`include "neuralLayer_settings.svh"

module neuralLayerTb;

	import neuralLayerPkg::*;

	typedef enum int
	{
		keepWeights,
		fixedWeights,
		randomWeights,
		singleNeuron
	} weightSet_t;

	localparam int ROWS = 6;
	localparam int RESET_CYCLES = 16;

	// One row per test
	// Only the last row holds back downstream credits
	string rowName [ROWS] = '{"resetZero", "fixedWeights", "randomWeights", "singleNeuron",
		"backToBack", "creditsWithheld"};
	weightSet_t rowWeights [ROWS] = '{keepWeights, fixedWeights, randomWeights, singleNeuron,
		randomWeights, randomWeights};
	int rowVectors [ROWS] = '{6, 8, 10, 6, 16, `QUEUE_DEPTH};
	int rowHold [ROWS] = '{0, 0, 0, 0, 0, 24};

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic weightValid;
	weightWrite_t weightData;
	logic inValid;
	featureVector_t inData;
	logic inCredit;
	logic outCredit;
	logic outValid;
	layerResult_t outData;

	// Reference copy of every weight and bias
	dataWord_t modelWeight [`LAYER_NEURONS][`LAYER_INPUTS];
	dataWord_t modelBias [`LAYER_NEURONS];
	layerResult_t expectedQ [$];

	string currentTest = "reset";
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int upstreamCredits = `QUEUE_DEPTH;
	int grantsOutstanding = 0;
	int rowResults = 0;
	int rowInCredits = 0;
	logic holdCredits = 1'b0;
	logic grantNext = 1'b0;

	neuralLayer uut
	(
		.clk(clk),
		.reset(reset),
		.weightValid(weightValid),
		.weightData(weightData),
		.inValid(inValid),
		.inData(inData),
		.inCredit(inCredit),
		.outCredit(outCredit),
		.outValid(outValid),
		.outData(outData)
	);

	always #2 clk = ~clk;

	function automatic int writesFor(input weightSet_t mode);
		if (mode == keepWeights)
			return 0;
		return `LAYER_NEURONS * (`LAYER_INPUTS + 1) + (mode == singleNeuron ? 2 : 0);
	endfunction

	// Full precision sum reduced modulo 256 and clamped on bit 7
	function automatic layerResult_t modelResult(input featureVector_t vec);
		layerResult_t expected;
		int acc;
		logic [`DATA_WIDTH-1:0] wrapped;
		for (int n = 0; n < `LAYER_NEURONS; n++)
		begin
			acc = int'(modelBias[n]);
			for (int i = 0; i < `LAYER_INPUTS; i++)
				acc = acc + int'(vec.data[i]) * int'(modelWeight[n][i]);
			wrapped = acc[`DATA_WIDTH-1:0];
			expected.activation[n] = wrapped[`DATA_WIDTH-1] ? '0 : wrapped;
		end
		return expected;
	endfunction

	function automatic featureVector_t randomVector();
		featureVector_t vec;
		for (int i = 0; i < `LAYER_INPUTS; i++)
			vec.data[i] = dataWord_t'($urandom);
		return vec;
	endfunction

	task automatic compareResult(input layerResult_t expected, input layerResult_t actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %h, actual %h", currentTest, expected, actual);
			errorCount++;
		end
	endtask

	task automatic compareCount(input string what, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("FAILED %s %s: expected %0d, actual %0d", currentTest, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportProblem(input string text);
		$display("ERROR %s: %s", currentTest, text);
		errorCount++;
	endtask

	task automatic writeRegister(input weightOp_t op, input int neuron, input int index,
		input dataWord_t value);
		@(posedge clk);
		#1;
		weightValid = 1'b1;
		weightData.op = op;
		weightData.neuronIndex = neuron[$clog2(`LAYER_NEURONS)-1:0];
		weightData.inputIndex = index[$clog2(`LAYER_INPUTS)-1:0];
		weightData.value = value;
		if (op == opBias)
			modelBias[neuron] = value;
		else
			modelWeight[neuron][index] = value;
		@(posedge clk);
		#1;
		weightValid = 1'b0;
	endtask

	task automatic loadWeights(input weightSet_t mode);
		dataWord_t value;
		if (mode != keepWeights)
		begin
			for (int n = 0; n < `LAYER_NEURONS; n++)
			begin
				for (int i = 0; i <= `LAYER_INPUTS; i++)
				begin
					case (mode)
						fixedWeights: value = dataWord_t'(n * 53 + i * 29 + 17 - 3 * n * i);
						randomWeights: value = dataWord_t'($urandom);
						default: value = '0;
					endcase
					// Index LAYER_INPUTS stands for the bias
					if (i == `LAYER_INPUTS)
						writeRegister(opBias, n, 0, value);
					else
						writeRegister(opWeight, n, i, value);
				end
			end
		end
		// One weight and the bias of neuron 2 on an otherwise cleared layer
		if (mode == singleNeuron)
		begin
			writeRegister(opWeight, 2, 5, dataWord_t'(7));
			writeRegister(opBias, 2, 0, dataWord_t'(1));
		end
	endtask

	task automatic sendVectors(input int count);
		featureVector_t vec;
		int sent;
		sent = 0;
		while (sent < count)
		begin
			@(posedge clk);
			#1;
			if (upstreamCredits > 0)
			begin
				vec = randomVector();
				inValid = 1'b1;
				inData = vec;
				expectedQ.push_back(modelResult(vec));
				upstreamCredits--;
				sent++;
			end
			else
				inValid = 1'b0;
		end
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	task automatic runRow(input int r);
		int errorsBefore;
		errorsBefore = errorCount;
		currentTest = rowName[r];
		rowResults = 0;
		rowInCredits = 0;
		loadWeights(rowWeights[r]);
		holdCredits = rowHold[r] > 0;
		sendVectors(rowVectors[r]);
		if (rowHold[r] > 0)
		begin
			repeat (rowHold[r]) @(posedge clk);
			compareCount("upstream credits while held", 0, upstreamCredits);
			compareCount("results while held", 0, rowResults);
			compareCount("inCredit pulses while held", 0, rowInCredits);
			holdCredits = 1'b0;
		end
		while (expectedQ.size() != 0)
			@(posedge clk);
		compareCount("results", rowVectors[r], rowResults);
		compareCount("inCredit pulses", rowVectors[r], rowInCredits);
		compareCount("upstream credits after drain", `QUEUE_DEPTH, upstreamCredits);
		if (errorCount == errorsBefore)
		begin
			passCount++;
			$display("test %s passed with %0d results", currentTest, rowResults);
		end
		else
		begin
			failCount++;
			$display("test %s failed with %0d errors", currentTest, errorCount - errorsBefore);
		end
	endtask

	// Outputs sampled and credits decided on the falling edge
	always @(negedge clk)
	begin
		if (outValid)
		begin
			rowResults++;
			grantsOutstanding--;
			if (expectedQ.size() == 0)
				reportProblem("a result arrived when none was expected");
			else
				compareResult(expectedQ.pop_front(), outData);
		end
		if (inCredit)
		begin
			rowInCredits++;
			upstreamCredits++;
		end
		if (outValid !== inCredit && !reset)
			reportProblem("inCredit did not pulse together with outValid");
		grantNext = 1'b0;
		if (!holdCredits && grantsOutstanding < `QUEUE_DEPTH
			&& grantsOutstanding < expectedQ.size())
		begin
			grantNext = 1'b1;
			grantsOutstanding++;
		end
	end

	// Downstream credit driver
	always @(posedge clk)
	begin
		#1;
		outCredit = grantNext;
	end

	initial
	begin
		int limit;
		wait (!reset);
		limit = 40;
		for (int r = 0; r < ROWS; r++)
			limit += rowVectors[r] + rowHold[r] + 2 * writesFor(rowWeights[r]) + 40;
		repeat (limit) @(posedge clk);
		$display("Timeout after %0d cycles, outputs stopped arriving in test %s",
			limit, currentTest);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		int seedValue;
		seedValue = $urandom(50415);
		weightValid = 1'b0;
		weightData = '0;
		inValid = 1'b0;
		inData = '0;
		outCredit = 1'b0;
		for (int n = 0; n < `LAYER_NEURONS; n++)
		begin
			modelBias[n] = '0;
			for (int i = 0; i < `LAYER_INPUTS; i++)
				modelWeight[n][i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int r = 0; r < ROWS; r++)
			runRow(r);
		$display("Tests: %0d passed, %0d failed", passCount, failCount);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
